// File: common/graphics_cfg.svh
`ifndef GRAPHICS_CFG_SVH
`define GRAPHICS_CFG_SVH

// kitchen grid placement, in pixels
`define GRID_X0        112
`define GRID_Y0        112
`define TILE_SIZE      32
`define GRID_COLS      13
`define GRID_ROWS      8

// player box and its facing strip
`define SPRITE_SIZE    16
`define FACE_STRIP     4
`define ITEM_MARGIN    4   // clear border around an object in its tile

// register map
`define REG_CTRL        12'h000
`define REG_PLAYER_BASE 12'h010
`define REG_GRID_BASE   12'h400

`define TRANSPARENT    12'hFFF

`endif

// File: common/video_pkg.sv
`default_nettype none

package video_pkg;

    typedef logic [11:0] color_t;  // rgb444

    // one beat from the video timing source
    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
        logic        hsync;   // active low
        logic        vsync;   // active low
        logic        blank;
    } pix_beat_t;

    // output of a render layer
    typedef struct packed {
        color_t color;
        logic   hit;
    } layer_px_t;

    localparam color_t BG_COLOR      = 12'h223;
    localparam color_t COUNTER_COLOR = 12'h852;
    localparam color_t FLOOR_A_COLOR = 12'hBBA;
    localparam color_t FLOOR_B_COLOR = 12'h998;

endpackage

`default_nettype wire

// File: common/game_pkg.sv
`default_nettype none
`include "graphics_cfg.svh"

package game_pkg;

    import video_pkg::*;

    typedef enum logic [3:0] {
        OBJ_EMPTY, OBJ_ONION_WHOLE, OBJ_ONION_CHOPPED, OBJ_BOWL_EMPTY, OBJ_BOWL_FULL,
        OBJ_POT_EMPTY, OBJ_POT_RAW, OBJ_POT_COOKED, OBJ_POT_FIRE, OBJ_FIRE, OBJ_EXTINGUISHER
    } object_t;

    typedef enum logic [1:0] {DIR_UP, DIR_DOWN, DIR_LEFT, DIR_RIGHT} dir_t;

    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
        dir_t       dir;
        object_t    held;
    } player_t;

    typedef struct packed {
        logic [1:0]                                num_players_m1;
        player_t [3:0]                             players;
        object_t [`GRID_ROWS-1:0][`GRID_COLS-1:0] cells;
    } game_state_t;

    // register map decode
    typedef enum logic [1:0] {SEL_NONE, SEL_CTRL, SEL_PLAYER, SEL_GRID} reg_region_t;
    typedef enum logic [1:0] {RESP_OKAY = 2'b00, RESP_SLVERR = 2'b10} axi_resp_t;

    typedef struct packed {
        reg_region_t region;
        logic [1:0]  player;
        logic [2:0]  row;
        logic [3:0]  col;
    } reg_sel_t;

    function automatic color_t object_color(input object_t obj);
        case (obj)
            OBJ_ONION_WHOLE:   return 12'hDA4;
            OBJ_ONION_CHOPPED: return 12'hEE8;
            OBJ_BOWL_EMPTY:    return 12'hEEE;
            OBJ_BOWL_FULL:     return 12'hE94;
            OBJ_POT_EMPTY:     return 12'h555;
            OBJ_POT_RAW:       return 12'h5A5;
            OBJ_POT_COOKED:    return 12'hA73;
            OBJ_POT_FIRE:      return 12'hF40;
            OBJ_FIRE:          return 12'hF80;
            OBJ_EXTINGUISHER:  return 12'hD11;
            default:           return 12'hF0F;  // empty or undefined code
        endcase
    endfunction

    function automatic color_t player_color(input logic [1:0] idx);
        case (idx)
            2'd0:    return 12'h22F;
            2'd1:    return 12'hF22;
            2'd2:    return 12'h2C2;
            default: return 12'hFC0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: logic/game_state_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "graphics_cfg.svh"

module game_state_regs import game_pkg::*; (
    input  wire               clock,
    input  wire               rst,
    input  wire  [11:0]       awaddr,
    input  wire               awvalid,
    output logic              awready,
    input  wire  [31:0]       wdata,
    input  wire  [3:0]        wstrb,
    input  wire               wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  wire               bready,
    input  wire  [11:0]       araddr,
    input  wire               arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  wire               rready,
    output game_state_t       state
);

    localparam logic [9:0] CTRL_WORD  = 10'(`REG_CTRL >> 2);
    localparam logic [7:0] PLAYER_BLK = 8'(`REG_PLAYER_BASE >> 4);
    localparam logic [2:0] GRID_BLK   = 3'(`REG_GRID_BASE >> 9);  // 8 rows of 16 words

    function automatic reg_sel_t decode(input logic [11:0] addr);
        reg_sel_t sel;
        sel.region = SEL_NONE;
        sel.player = addr[3:2];
        sel.row    = addr[8:6];
        sel.col    = addr[5:2];
        if (addr[11:2] == CTRL_WORD)
            sel.region = SEL_CTRL;
        else if (addr[11:4] == PLAYER_BLK)
            sel.region = SEL_PLAYER;
        else if (addr[11:9] == GRID_BLK && sel.col < 4'(`GRID_COLS))
            sel.region = SEL_GRID;  // cols 13..15 stay unmapped
        return sel;
    endfunction

    function automatic logic [31:0] read_word(input reg_sel_t sel, input game_state_t st);
        player_t p;
        p = st.players[sel.player];
        case (sel.region)
            SEL_CTRL:   return {30'd0, st.num_players_m1};
            SEL_PLAYER: return {p.held, p.dir, 1'b0, p.y, 7'd0, p.x};
            SEL_GRID:   return {28'd0, st.cells[sel.row][sel.col]};
            default:    return 32'd0;
        endcase
    endfunction

    reg_sel_t    wsel;
    reg_sel_t    rsel;
    logic        wr_accept;
    logic        rd_accept;
    logic [31:0] wmerged;

    assign wsel      = decode(awaddr);
    assign rsel      = decode(araddr);
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && arready;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = !rvalid;

    // byte strobes over the current contents
    always_comb begin
        wmerged = read_word(wsel, state);
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b])
                wmerged[8*b +: 8] = wdata[8*b +: 8];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state  <= '0;
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
            case (wsel.region)
                SEL_CTRL: state.num_players_m1 <= wmerged[1:0];
                SEL_PLAYER: begin
                    state.players[wsel.player].x    <= wmerged[8:0];
                    state.players[wsel.player].y    <= wmerged[24:16];
                    state.players[wsel.player].dir  <= dir_t'(wmerged[27:26]);
                    state.players[wsel.player].held <= object_t'(wmerged[31:28]);
                end
                SEL_GRID: state.cells[wsel.row][wsel.col] <= object_t'(wmerged[3:0]);
                default: ;  // unmapped, dropped
            endcase
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_accept)
            bresp <= (wsel.region == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
    end

    always_ff @(posedge clock) begin
        if (rst)
            rvalid <= 1'b0;
        else if (rd_accept)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // held stable while rvalid waits, arready is low then
    always_ff @(posedge clock) begin
        if (rd_accept) begin
            rdata <= read_word(rsel, state);
            rresp <= (rsel.region == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// File: logic/player_layer.sv
`timescale 1ns/1ps
`default_nettype none
`include "graphics_cfg.svh"

module player_layer import video_pkg::*, game_pkg::*; (
    input  wire               clock,
    input  wire               rst,
    input  wire  pix_beat_t   beat_in,
    input  wire  game_state_t state,
    output layer_px_t         px
);

    localparam logic [10:0] SPR_X   = 11'(`SPRITE_SIZE);
    localparam logic [9:0]  SPR_Y   = 10'(`SPRITE_SIZE);
    localparam logic [10:0] STRIP_X = 11'(`FACE_STRIP);
    localparam logic [9:0]  STRIP_Y = 10'(`FACE_STRIP);

    function automatic layer_px_t sprite_px(input player_t p, input logic [1:0] idx,
                                            input pix_beat_t b);
        logic [10:0] dx;
        logic [9:0]  dy;
        logic        in_box;
        logic        in_strip;
        layer_px_t   res;
        // offsets wrap to large values left of or above the box
        dx = b.hcount - {2'b00, p.x};
        dy = b.vcount - {1'b0, p.y};
        in_box = (dx < SPR_X) && (dy < SPR_Y);
        case (p.dir)
            DIR_UP:   in_strip = dy < STRIP_Y;
            DIR_DOWN: in_strip = dy >= SPR_Y - STRIP_Y;
            DIR_LEFT: in_strip = dx < STRIP_X;
            default:  in_strip = dx >= SPR_X - STRIP_X;  // right
        endcase
        res.hit = in_box;
        if (!in_box)
            res.color = `TRANSPARENT;
        else if (in_strip && p.held != OBJ_EMPTY)
            res.color = object_color(p.held);  // held item shows on facing edge
        else
            res.color = player_color(idx);
        return res;
    endfunction

    layer_px_t px_next;

    always_comb begin
        layer_px_t cand;
        px_next.color = `TRANSPARENT;
        px_next.hit   = 1'b0;
        // walk downwards so the lowest index is applied last
        for (int i = 3; i >= 0; i--) begin
            cand = sprite_px(state.players[i], 2'(i), beat_in);
            if (2'(i) <= state.num_players_m1 && cand.hit)
                px_next = cand;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            px.color <= `TRANSPARENT;
            px.hit   <= 1'b0;
        end else begin
            px <= px_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/tile_layer.sv
`timescale 1ns/1ps
`default_nettype none
`include "graphics_cfg.svh"

module tile_layer import video_pkg::*, game_pkg::*; (
    input  wire               clock,
    input  wire               rst,
    input  wire  pix_beat_t   beat_in,
    input  wire  game_state_t state,
    output layer_px_t         px,
    output pix_beat_t         beat_out
);

    localparam logic [10:0] X_LO     = 11'(`GRID_X0);
    localparam logic [10:0] X_HI     = 11'(`GRID_X0 + `GRID_COLS * `TILE_SIZE);
    localparam logic [9:0]  Y_LO     = 10'(`GRID_Y0);
    localparam logic [9:0]  Y_HI     = 10'(`GRID_Y0 + `GRID_ROWS * `TILE_SIZE);
    localparam logic [4:0]  IN_LO    = 5'(`ITEM_MARGIN);
    localparam logic [4:0]  IN_HI    = 5'(`TILE_SIZE - `ITEM_MARGIN);
    localparam logic [2:0]  LAST_ROW = 3'(`GRID_ROWS - 1);
    localparam logic [3:0]  LAST_COL = 4'(`GRID_COLS - 1);

    logic [10:0] gx;
    logic [9:0]  gy;
    logic [3:0]  col;
    logic [2:0]  row;
    logic [4:0]  ox;
    logic [4:0]  oy;
    logic        in_grid;
    logic        inner;
    logic        border;
    object_t     obj;
    color_t      color_next;

    assign gx      = beat_in.hcount - X_LO;
    assign gy      = beat_in.vcount - Y_LO;
    assign in_grid = beat_in.hcount >= X_LO && beat_in.hcount < X_HI &&
                     beat_in.vcount >= Y_LO && beat_in.vcount < Y_HI;
    assign col     = 4'(gx / `TILE_SIZE);
    assign row     = 3'(gy / `TILE_SIZE);
    assign ox      = 5'(gx % `TILE_SIZE);  // offset within the tile
    assign oy      = 5'(gy % `TILE_SIZE);
    assign inner   = ox >= IN_LO && ox < IN_HI && oy >= IN_LO && oy < IN_HI;
    assign border  = row == 3'd0 || row == LAST_ROW || col == 4'd0 || col == LAST_COL;
    assign obj     = in_grid ? state.cells[row][col] : OBJ_EMPTY;

    always_comb begin
        if (!in_grid)
            color_next = BG_COLOR;
        else if (obj != OBJ_EMPTY && inner)
            color_next = object_color(obj);
        else if (border)
            color_next = COUNTER_COLOR;
        else if ((row[0] ^ col[0]) == 1'b0)  // checkerboard on row + col
            color_next = FLOOR_A_COLOR;
        else
            color_next = FLOOR_B_COLOR;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            px.color        <= BG_COLOR;
            px.hit          <= 1'b1;
            beat_out.hcount <= '0;
            beat_out.vcount <= '0;
            beat_out.hsync  <= 1'b1;  // syncs idle high
            beat_out.vsync  <= 1'b1;
            beat_out.blank  <= 1'b1;
        end else begin
            px.color <= color_next;
            px.hit   <= 1'b1;  // tile layer always covers
            beat_out <= beat_in;
        end
    end

endmodule

`default_nettype wire

// File: logic/pixel_compositor.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor import video_pkg::*; (
    input  wire             clock,
    input  wire             rst,
    input  wire  layer_px_t player_px,
    input  wire  layer_px_t tile_px,
    input  wire  pix_beat_t beat_in,
    output color_t          pixel_out,
    output logic            hsync_out,
    output logic            vsync_out,
    output logic            blank_out
);

    color_t mixed;

    // players over tiles, background if neither layer covers
    always_comb begin
        if (player_px.hit)
            mixed = player_px.color;
        else if (tile_px.hit)
            mixed = tile_px.color;
        else
            mixed = BG_COLOR;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pixel_out <= '0;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            blank_out <= 1'b1;
        end else begin
            pixel_out <= beat_in.blank ? '0 : mixed;  // black during blanking
            hsync_out <= beat_in.hsync;
            vsync_out <= beat_in.vsync;
            blank_out <= beat_in.blank;
        end
    end

endmodule

`default_nettype wire

// File: logic/graphics.sv
`timescale 1ns/1ps
`default_nettype none

module graphics import video_pkg::*, game_pkg::*; (
    input  wire             clock,
    input  wire             rst,
    input  wire  [11:0]     awaddr,
    input  wire             awvalid,
    output logic            awready,
    input  wire  [31:0]     wdata,
    input  wire  [3:0]      wstrb,
    input  wire             wvalid,
    output logic            wready,
    output logic [1:0]      bresp,
    output logic            bvalid,
    input  wire             bready,
    input  wire  [11:0]     araddr,
    input  wire             arvalid,
    output logic            arready,
    output logic [31:0]     rdata,
    output logic [1:0]      rresp,
    output logic            rvalid,
    input  wire             rready,
    input  wire  pix_beat_t beat_in,
    output color_t          pixel_out,
    output logic            hsync_out,
    output logic            vsync_out,
    output logic            blank_out
);

    game_state_t game_state;
    layer_px_t   player_px;
    layer_px_t   tile_px;
    pix_beat_t   beat_s1;  // beat aligned with the stage 1 layers

    game_state_regs u_regs (
        .clock(clock), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .state(game_state)
    );

    player_layer u_player_layer (
        .clock(clock), .rst(rst), .beat_in(beat_in), .state(game_state), .px(player_px)
    );

    tile_layer u_tile_layer (
        .clock(clock), .rst(rst), .beat_in(beat_in), .state(game_state),
        .px(tile_px), .beat_out(beat_s1)
    );

    pixel_compositor u_compositor (
        .clock(clock), .rst(rst), .player_px(player_px), .tile_px(tile_px),
        .beat_in(beat_s1), .pixel_out(pixel_out), .hsync_out(hsync_out),
        .vsync_out(vsync_out), .blank_out(blank_out)
    );

endmodule

`default_nettype wire

// File: verification/graphics_checker.sv
`timescale 1ns/1ps
`default_nettype none

module graphics_checker (
    input wire        clock,
    input wire        rst,
    input wire        bvalid,
    input wire        bready,
    input wire        rvalid,
    input wire        rready,
    input wire [31:0] rdata,
    input wire [1:0]  rresp,
    input wire [11:0] pixel_out,
    input wire        hsync_out,
    input wire        vsync_out,
    input wire        blank_out
);

    bresp_hold: assert property (@(posedge clock) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rdata_hold: assert property (@(posedge clock) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("read response changed while waiting for rready");

    blank_black: assert property (@(posedge clock) disable iff (rst)
        blank_out |-> pixel_out == 12'h000)
        else $error("pixel not black during blanking");

    // syncs are active low, so idle high
    reset_values: assert property (@(posedge clock)
        rst |=> pixel_out == 12'h000 && hsync_out && vsync_out && blank_out)
        else $error("outputs not at reset values after rst");

endmodule

bind graphics graphics_checker u_checker (.*);

`default_nettype wire

// File: verification/graphics_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "graphics_cfg.svh"

module graphics_tb import video_pkg::*; ();

    typedef struct packed {
        logic   valid;
        color_t pix;
        logic   hs;
        logic   vs;
        logic   blank;
    } exp_t;

    // beats of all tests plus drain cycles, and bus ops at about 5 cycles each
    localparam int TOTAL_BEATS = 60 + 60 + 300 + 4 * 400 + 2 * 1296 + 200 + 6 * 8;
    localparam int BUS_CYCLES  = 180 * 5;
    localparam int LIMIT       = 2 * (TOTAL_BEATS + BUS_CYCLES) + 200;

    logic        clock = 1'b0;
    logic        rst;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    pix_beat_t   beat_in;
    color_t      pixel_out;
    logic        hsync_out;
    logic        vsync_out;
    logic        blank_out;

    // testbench copy of the game state
    int   m_nump;
    int   m_x[4];
    int   m_y[4];
    int   m_dir[4];
    int   m_held[4];
    int   m_cell[8][13];

    integer seed = 22;
    int     cycles = 0;
    int     n_checks = 0;
    int     n_errors = 0;
    int     n_tests = 0;
    string  cur_test = "reset";
    exp_t   cur_exp;
    exp_t   exp_q[$];

    graphics u_graphics (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run exceeded %0d cycles", LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic color_t obj_rgb(input int o);
        case (o)
            1:       return 12'hDA4;
            2:       return 12'hEE8;
            3:       return 12'hEEE;
            4:       return 12'hE94;
            5:       return 12'h555;
            6:       return 12'h5A5;
            7:       return 12'hA73;
            8:       return 12'hF40;
            9:       return 12'hF80;
            10:      return 12'hD11;
            default: return 12'hF0F;
        endcase
    endfunction

    function automatic color_t body_rgb(input int i);
        case (i)
            0:       return 12'h22F;
            1:       return 12'hF22;
            2:       return 12'h2C2;
            default: return 12'hFC0;
        endcase
    endfunction

    function automatic color_t ref_pixel(input int hc, input int vc, input logic bl);
        int     dx;
        int     dy;
        int     row;
        int     col;
        int     ox;
        int     oy;
        int     i;
        logic   strip;
        color_t c;
        if (bl)
            return 12'h000;
        c = BG_COLOR;
        dx = hc - `GRID_X0;
        dy = vc - `GRID_Y0;
        if (dx >= 0 && dx < `GRID_COLS * `TILE_SIZE && dy >= 0 && dy < `GRID_ROWS * `TILE_SIZE) begin
            col = dx / `TILE_SIZE;
            row = dy / `TILE_SIZE;
            ox  = dx % `TILE_SIZE;
            oy  = dy % `TILE_SIZE;
            if (m_cell[row][col] != 0 && ox >= `ITEM_MARGIN && oy >= `ITEM_MARGIN &&
                ox < `TILE_SIZE - `ITEM_MARGIN && oy < `TILE_SIZE - `ITEM_MARGIN)
                c = obj_rgb(m_cell[row][col]);
            else if (row == 0 || row == `GRID_ROWS - 1 || col == 0 || col == `GRID_COLS - 1)
                c = COUNTER_COLOR;
            else if ((row + col) % 2 == 0)
                c = FLOOR_A_COLOR;
            else
                c = FLOOR_B_COLOR;
        end
        // highest index first so player 0 ends on top
        for (i = 3; i >= 0; i--) begin
            dx = hc - m_x[i];
            dy = vc - m_y[i];
            if (i <= m_nump && dx >= 0 && dx < `SPRITE_SIZE && dy >= 0 && dy < `SPRITE_SIZE) begin
                case (m_dir[i])
                    0:       strip = dy < `FACE_STRIP;
                    1:       strip = dy >= `SPRITE_SIZE - `FACE_STRIP;
                    2:       strip = dx < `FACE_STRIP;
                    default: strip = dx >= `SPRITE_SIZE - `FACE_STRIP;
                endcase
                c = (strip && m_held[i] != 0) ? obj_rgb(m_held[i]) : body_rgb(i);
            end
        end
        return c;
    endfunction

    // unmapped addresses leave the copy untouched
    function automatic void model_write(input logic [11:0] a, input logic [31:0] d);
        if (a == `REG_CTRL) begin
            m_nump = d[1:0];
        end else if (a[11:4] == 8'(`REG_PLAYER_BASE >> 4)) begin
            m_x[a[3:2]]    = d[8:0];
            m_y[a[3:2]]    = d[24:16];
            m_dir[a[3:2]]  = d[27:26];
            m_held[a[3:2]] = d[31:28];
        end else if (a[11:9] == 3'(`REG_GRID_BASE >> 9) && a[5:2] < `GRID_COLS) begin
            m_cell[a[8:6]][a[5:2]] = d[3:0];
        end
    endfunction

    function automatic logic [31:0] model_word(input logic [11:0] a);
        logic [31:0] w;
        w = '0;
        if (a == `REG_CTRL) begin
            w[1:0] = m_nump[1:0];
        end else if (a[11:4] == 8'(`REG_PLAYER_BASE >> 4)) begin
            w[8:0]   = m_x[a[3:2]][8:0];
            w[24:16] = m_y[a[3:2]][8:0];
            w[27:26] = m_dir[a[3:2]][1:0];
            w[31:28] = m_held[a[3:2]][3:0];
        end else begin
            w[3:0] = m_cell[a[8:6]][a[5:2]][3:0];
        end
        return w;
    endfunction

    // pipeline of expectations, two beats in flight
    always @(posedge clock) begin
        exp_q.push_back(cur_exp);
        if (exp_q.size() > 2)
            void'(exp_q.pop_front());
    end

    always @(negedge clock) begin
        if (exp_q.size() == 2 && exp_q[0].valid) begin
            n_checks++;
            assert (pixel_out == exp_q[0].pix && blank_out == exp_q[0].blank &&
                    hsync_out == exp_q[0].hs && vsync_out == exp_q[0].vs)
            else begin
                n_errors++;
                $display("[FAIL] %s: expected pix %h hs %b vs %b blank %b, actual %h %b %b %b",
                         cur_test, exp_q[0].pix, exp_q[0].hs, exp_q[0].vs, exp_q[0].blank,
                         pixel_out, hsync_out, vsync_out, blank_out);
            end
        end
    end

    task automatic bus_write(input logic [11:0] a, input logic [31:0] d, output logic [1:0] resp);
        @(posedge clock);
        #1;
        awaddr  = a;
        wdata   = d;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!awready) begin
            @(posedge clock);
            #2;
        end
        n_checks++;
        assert (wready)
        else begin
            n_errors++;
            $display("[FAIL] %s: wready not raised together with awready", cur_test);
        end
        @(posedge clock);
        model_write(a, d);  // takes effect for beats from this edge on
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) begin
            @(posedge clock);
            #1;
        end
        resp = bresp;
        repeat (2) @(posedge clock);  // response held back by bready
        #1;
        bready = 1'b1;
        @(posedge clock);
        #1;
        bready = 1'b0;
    endtask

    task automatic bus_read(input logic [11:0] a, output logic [31:0] d, output logic [1:0] resp);
        @(posedge clock);
        #1;
        araddr  = a;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(posedge clock);
            #2;
        end
        @(posedge clock);
        #1;
        arvalid = 1'b0;
        while (!rvalid) begin
            @(posedge clock);
            #1;
        end
        d    = rdata;
        resp = rresp;
        repeat (2) @(posedge clock);  // data held back by rready
        #1;
        rready = 1'b1;
        @(posedge clock);
        #1;
        rready = 1'b0;
    endtask

    task automatic write_ok(input logic [11:0] a, input logic [31:0] d);
        logic [1:0] resp;
        bus_write(a, d, resp);
        n_checks++;
        assert (resp == 2'b00)
        else begin
            n_errors++;
            $display("[FAIL] %s: write %h expected resp 0 actual %0d", cur_test, a, resp);
        end
    endtask

    task automatic drive_beat(input int hc, input int vc, input logic hs, input logic vs,
                              input logic bl);
        @(posedge clock);
        #1;
        beat_in.hcount = 11'(hc);
        beat_in.vcount = 10'(vc);
        beat_in.hsync  = hs;
        beat_in.vsync  = vs;
        beat_in.blank  = bl;
        cur_exp = '{valid: 1'b1, pix: ref_pixel(hc, vc, bl), hs: hs, vs: vs, blank: bl};
    endtask

    task automatic stop_stream();
        @(posedge clock);
        #1;
        cur_exp.valid = 1'b0;
        beat_in.blank = 1'b1;
        repeat (4) @(posedge clock);
    endtask

    task automatic grid_beat();
        drive_beat(`GRID_X0 + {$random(seed)} % (`GRID_COLS * `TILE_SIZE),
                   `GRID_Y0 + {$random(seed)} % (`GRID_ROWS * `TILE_SIZE), 1'b1, 1'b1, 1'b0);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        n_tests++;
    endtask

    task automatic end_test(input int checks0, input int errors0);
        $display("test %-10s %0d checks, %0d errors", cur_test,
                 n_checks - checks0, n_errors - errors0);
    endtask

    function automatic logic [11:0] cell_addr(input int row, input int col);
        return 12'(`REG_GRID_BASE + 4 * (16 * row + col));
    endfunction

    initial begin
        int          c0;
        int          e0;
        logic [11:0] a;
        logic [31:0] d;
        logic [31:0] got;
        logic [1:0]  resp;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = 4'hF;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        beat_in = '{hcount: '0, vcount: '0, hsync: 1'b1, vsync: 1'b1, blank: 1'b1};
        cur_exp = '0;
        m_nump = 0;
        for (int i = 0; i < 4; i++) begin
            m_x[i] = 0;
            m_y[i] = 0;
            m_dir[i] = 0;
            m_held[i] = 0;
        end
        for (int r = 0; r < 8; r++)
            for (int c = 0; c < 13; c++)
                m_cell[r][c] = 0;
        repeat (4) @(posedge clock);
        #1 rst = 1'b0;

        begin_test("regs");
        c0 = n_checks;
        e0 = n_errors;
        for (int k = 0; k < 14; k++) begin
            a = (k < 4) ? 12'(`REG_PLAYER_BASE + 4 * k)
                        : cell_addr({$random(seed)} % 8, {$random(seed)} % 13);
            d = $random(seed);
            write_ok(a, d);
            bus_read(a, got, resp);
            n_checks++;
            assert (got == model_word(a) && resp == 2'b00)
            else begin
                n_errors++;
                $display("[FAIL] %s: addr %h expected %h actual %h", cur_test, a,
                         model_word(a), got);
            end
        end
        for (int j = 0; j < 2; j++) begin
            a = (j == 0) ? cell_addr(3, 13) : 12'h100;
            d = model_word(cell_addr(4, 0));
            bus_write(a, 32'hFFFF_FFFF, resp);
            n_checks++;
            assert (resp == 2'b10)
            else begin
                n_errors++;
                $display("[FAIL] %s: write %h expected resp 2 actual %0d", cur_test, a, resp);
            end
            bus_read(a, got, resp);
            n_checks++;
            assert (resp == 2'b10)
            else begin
                n_errors++;
                $display("[FAIL] %s: addr %h expected resp 2 actual %0d", cur_test, a, resp);
            end
            bus_read(cell_addr(4, 0), got, resp);
            n_checks++;
            assert (got == d)
            else begin
                n_errors++;
                $display("[FAIL] %s: unmapped write changed state, expected %h actual %h",
                         cur_test, d, got);
            end
        end
        end_test(c0, e0);

        // park every player off the grid
        for (int i = 0; i < 4; i++)
            write_ok(12'(`REG_PLAYER_BASE + 4 * i), 32'h0);
        write_ok(`REG_CTRL, 32'h0);

        begin_test("blanking");
        c0 = n_checks;
        e0 = n_errors;
        for (int k = 0; k < 60; k++)
            drive_beat((k % 2) ? {$random(seed)} % `GRID_X0 : 528 + {$random(seed)} % 272,
                       {$random(seed)} % 525, $random(seed), $random(seed), 1'b0);
        for (int k = 0; k < 60; k++)
            drive_beat({$random(seed)} % 800, {$random(seed)} % 525, $random(seed),
                       $random(seed), 1'b1);
        stop_stream();
        end_test(c0, e0);

        begin_test("tiles");
        c0 = n_checks;
        e0 = n_errors;
        for (int r = 0; r < 8; r++)
            for (int c = 0; c < 13; c++)
                write_ok(cell_addr(r, c), {$random(seed)} % 11);
        for (int k = 0; k < 300; k++)
            grid_beat();
        stop_stream();
        end_test(c0, e0);

        begin_test("players");
        c0 = n_checks;
        e0 = n_errors;
        for (int dir = 0; dir < 4; dir++) begin
            write_ok(`REG_PLAYER_BASE, {4'(dir + 1), 2'(dir), 1'b0, 9'd150, 7'd0, 9'd200});
            for (int dy = -2; dy < 18; dy++)
                for (int dx = -2; dx < 18; dx++)
                    drive_beat(200 + dx, 150 + dy, 1'b1, 1'b1, 1'b0);
            stop_stream();
        end
        end_test(c0, e0);

        begin_test("priority");
        c0 = n_checks;
        e0 = n_errors;
        for (int i = 0; i < 4; i++)
            write_ok(12'(`REG_PLAYER_BASE + 4 * i),
                     {4'(i + 2), 2'(i), 1'b0, 9'(200 + 4 * i), 7'd0, 9'(200 + 4 * i)});
        for (int n = 1; n <= 3; n += 2) begin
            write_ok(`REG_CTRL, 32'(n));
            for (int vc = 196; vc < 232; vc++)
                for (int hc = 196; hc < 232; hc++)
                    drive_beat(hc, vc, 1'b1, 1'b1, 1'b0);
            stop_stream();
        end
        end_test(c0, e0);

        begin_test("live");
        c0 = n_checks;
        e0 = n_errors;
        write_ok(`REG_CTRL, 32'h0);
        write_ok(`REG_PLAYER_BASE, 32'h0);
        fork
            for (int k = 0; k < 200; k++)
                drive_beat(`GRID_X0 + 5 * `TILE_SIZE + {$random(seed)} % `TILE_SIZE,
                           `GRID_Y0 + 3 * `TILE_SIZE + {$random(seed)} % `TILE_SIZE,
                           1'b1, 1'b1, 1'b0);
            for (int k = 0; k < 6; k++) begin
                repeat (20) @(posedge clock);
                write_ok(cell_addr(3, 5), (k * 3 + 1) % 11);
            end
        join
        stop_stream();
        end_test(c0, e0);

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: graphics.f
+incdir+common
common/video_pkg.sv
common/game_pkg.sv
logic/game_state_regs.sv
logic/player_layer.sv
logic/tile_layer.sv
logic/pixel_compositor.sv
logic/graphics.sv
verification/graphics_checker.sv
verification/graphics_tb.sv

// File: Makefile
# Verilator build and run for the graphics testbench

VERILATOR ?= verilator
TOP       ?= graphics_tb
FILELIST  ?= graphics.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

PASS_TEXT := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
